// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 64;   // data width
    localparam int ILEN       = 32;   // instruction width
    localparam int REG_ADDR_W = 5;

    // ##############################
    // major opcodes, inst[6:0]
    // ##############################
    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b0000011,
        OPC_MISC_MEM  = 7'b0001111,
        OPC_OP_IMM    = 7'b0010011,
        OPC_AUIPC     = 7'b0010111,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_STORE     = 7'b0100011,
        OPC_OP        = 7'b0110011,
        OPC_LUI       = 7'b0110111,
        OPC_OP_32     = 7'b0111011,
        OPC_BRANCH    = 7'b1100011,
        OPC_JALR      = 7'b1100111,
        OPC_JAL       = 7'b1101111,
        OPC_SYSTEM    = 7'b1110011
    } opcode_e;

    // ##############################
    // integer operations
    // ##############################
    typedef enum logic [3:0] {
        ALU_NONE,   // consumed, nothing written back
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,    // SLTU when is_unsigned
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI,
        ALU_AUIPC
    } alu_op_e;

endpackage

// ==== rtl/inst_fifo.sv ====
`timescale 1ns/100ps

module inst_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [rv_pkg::ILEN-1:0] wb_dat_w,
    output logic                    wb_ack,
    output logic [rv_pkg::ILEN-1:0] wb_dat_r,
    input  logic                    pop,
    output logic                    empty,
    output logic [rv_pkg::ILEN-1:0] head
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [rv_pkg::ILEN-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count;
    logic                    full;
    logic                    push;
    logic                    do_pop;

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign head     = mem[rd_ptr];
    assign do_pop   = pop && !empty;
    assign push     = wb_cyc && wb_stb && wb_we && !wb_ack && !full;  // held off while full
    assign wb_dat_r = '0;    // write-only port, reads return zero

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wb_ack <= push || (wb_cyc && wb_stb && !wb_we && !wb_ack);
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !push)
                count <= count - 1'b1;
        end
    end

    // word lands on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wb_dat_w;
    end

endmodule

// ==== rtl/decoder.sv ====
`timescale 1ns/100ps

module decoder (
    input  logic                          empty,
    input  logic [rv_pkg::ILEN-1:0]       inst,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_pkg::REG_ADDR_W-1:0] rd,
    output logic [rv_pkg::XLEN-1:0]       src1,
    output logic [rv_pkg::XLEN-1:0]       src2,
    output logic [rv_pkg::XLEN-1:0]       imm,
    output rv_pkg::alu_op_e               alu_op,
    output logic                          is_imm,
    output logic                          is_word,
    output logic                          is_unsigned,
    output logic                          need_to_wb
);

    rv_pkg::opcode_e         opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_j;

    assign opcode = rv_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // ##############################
    // immediates, sign-extended
    // ##############################
    assign imm_i = {{(rv_pkg::XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(rv_pkg::XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(rv_pkg::XLEN-13){inst[31]}}, inst[31], inst[7],
                    inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{(rv_pkg::XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(rv_pkg::XLEN-21){inst[31]}}, inst[31], inst[19:12],
                    inst[20], inst[30:21], 1'b0};

    // ##############################
    // operation select
    // ##############################
    always_comb begin
        rs1         = inst[19:15];
        rs2         = inst[24:20];
        rd          = inst[11:7];
        src1        = rs1_data;
        src2        = rs2_data;
        imm         = '0;
        alu_op      = rv_pkg::ALU_NONE;
        is_imm      = 1'b0;
        is_word     = 1'b0;
        is_unsigned = 1'b0;
        if (!empty) begin
            case (opcode)
                rv_pkg::OPC_LUI: begin
                    imm    = imm_u;
                    alu_op = rv_pkg::ALU_LUI;
                end
                rv_pkg::OPC_AUIPC: begin
                    imm    = imm_u;
                    alu_op = rv_pkg::ALU_AUIPC;
                end
                rv_pkg::OPC_JAL:
                    imm = imm_j;
                rv_pkg::OPC_JALR, rv_pkg::OPC_LOAD:
                    imm = imm_i;
                rv_pkg::OPC_BRANCH:
                    imm = imm_b;
                rv_pkg::OPC_STORE:
                    imm = imm_s;
                rv_pkg::OPC_OP_IMM: begin
                    imm    = imm_i;
                    is_imm = 1'b1;
                    casez ({funct7, funct3})
                        10'b???????000: alu_op = rv_pkg::ALU_ADD;
                        10'b???????010: alu_op = rv_pkg::ALU_SLT;
                        10'b???????011: begin
                            alu_op      = rv_pkg::ALU_SLT;
                            is_unsigned = 1'b1;
                        end
                        10'b???????100: alu_op = rv_pkg::ALU_XOR;
                        10'b???????110: alu_op = rv_pkg::ALU_OR;
                        10'b???????111: alu_op = rv_pkg::ALU_AND;
                        10'b000000?001: alu_op = rv_pkg::ALU_SLL;  // shamt[5] in funct7[0]
                        10'b000000?101: alu_op = rv_pkg::ALU_SRL;
                        10'b010000?101: alu_op = rv_pkg::ALU_SRA;
                        default: ;
                    endcase
                end
                rv_pkg::OPC_OP: begin
                    case ({funct7, funct3})
                        10'b0000000000: alu_op = rv_pkg::ALU_ADD;
                        10'b0100000000: alu_op = rv_pkg::ALU_SUB;
                        10'b0000000001: alu_op = rv_pkg::ALU_SLL;
                        10'b0000000010: alu_op = rv_pkg::ALU_SLT;
                        10'b0000000011: begin
                            alu_op      = rv_pkg::ALU_SLT;
                            is_unsigned = 1'b1;
                        end
                        10'b0000000100: alu_op = rv_pkg::ALU_XOR;
                        10'b0000000101: alu_op = rv_pkg::ALU_SRL;
                        10'b0100000101: alu_op = rv_pkg::ALU_SRA;
                        10'b0000000110: alu_op = rv_pkg::ALU_OR;
                        10'b0000000111: alu_op = rv_pkg::ALU_AND;
                        default: ;
                    endcase
                end
                rv_pkg::OPC_OP_IMM_32: begin
                    imm     = imm_i;
                    is_imm  = 1'b1;
                    is_word = 1'b1;
                    casez ({funct7, funct3})
                        10'b???????000: alu_op = rv_pkg::ALU_ADD;
                        10'b0000000001: alu_op = rv_pkg::ALU_SLL;
                        10'b0000000101: alu_op = rv_pkg::ALU_SRL;
                        10'b0100000101: alu_op = rv_pkg::ALU_SRA;
                        default: ;
                    endcase
                end
                rv_pkg::OPC_OP_32: begin
                    is_word = 1'b1;
                    case ({funct7, funct3})
                        10'b0000000000: alu_op = rv_pkg::ALU_ADD;
                        10'b0100000000: alu_op = rv_pkg::ALU_SUB;
                        10'b0000000001: alu_op = rv_pkg::ALU_SLL;
                        10'b0000000101: alu_op = rv_pkg::ALU_SRL;
                        10'b0100000101: alu_op = rv_pkg::ALU_SRA;
                        default: ;
                    endcase
                end
                rv_pkg::OPC_MISC_MEM, rv_pkg::OPC_SYSTEM: ;  // fence, ecall, ebreak
                default: ;
            endcase
        end
        need_to_wb = (alu_op != rv_pkg::ALU_NONE);
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_pkg::XLEN-1:0]       rs2_data,
    input  logic                          we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wa,
    input  logic [rv_pkg::XLEN-1:0]       wd
);

    localparam int NREG = 2 ** rv_pkg::REG_ADDR_W;

    logic [rv_pkg::XLEN-1:0] regs [1:NREG-1];   // x0 has no storage

    // write-through, a result in writeback is already visible to decode
    function automatic logic [rv_pkg::XLEN-1:0] read_port(
        input logic [rv_pkg::REG_ADDR_W-1:0] a
    );
        if (a == '0)
            return '0;
        if (we && wa == a)
            return wd;
        return regs[a];
    endfunction

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NREG; i++)
                regs[i] <= '0;
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          empty,
    output logic                          pop,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
    input  logic [rv_pkg::XLEN-1:0]       src1,
    input  logic [rv_pkg::XLEN-1:0]       src2,
    input  logic [rv_pkg::XLEN-1:0]       imm,
    input  rv_pkg::alu_op_e               alu_op,
    input  logic                          is_imm,
    input  logic                          is_word,
    input  logic                          is_unsigned,
    input  logic                          need_to_wb,
    output logic                          wb_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [rv_pkg::XLEN-1:0]       wb_data
);

    logic [rv_pkg::XLEN-1:0]       pc;
    logic                          iss_wb;
    logic [rv_pkg::REG_ADDR_W-1:0] iss_rd;
    logic [rv_pkg::XLEN-1:0]       iss_src1;
    logic [rv_pkg::XLEN-1:0]       iss_src2;
    logic [rv_pkg::XLEN-1:0]       iss_imm;
    logic [rv_pkg::XLEN-1:0]       iss_pc;
    rv_pkg::alu_op_e               iss_op;
    logic                          iss_is_imm;
    logic                          iss_is_word;
    logic                          iss_is_unsigned;
    logic [rv_pkg::XLEN-1:0]       fwd_src1;
    logic [rv_pkg::XLEN-1:0]       fwd_src2;
    logic [rv_pkg::XLEN-1:0]       alu_result;

    assign pop = !empty;    // no stalls, forwarding covers every hazard

    // in-flight result overrides the register file
    assign fwd_src1 = (iss_wb && iss_rd != '0 && iss_rd == rs1) ? alu_result : src1;
    assign fwd_src2 = (iss_wb && iss_rd != '0 && iss_rd == rs2) ? alu_result : src2;

    // ##############################
    // issue register and pc
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            iss_wb   <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            iss_wb   <= pop && need_to_wb;
            wb_valid <= iss_wb;
            if (pop)
                pc <= pc + rv_pkg::XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            iss_rd          <= rd;
            iss_src1        <= fwd_src1;
            iss_src2        <= fwd_src2;
            iss_imm         <= imm;
            iss_pc          <= pc;
            iss_op          <= alu_op;
            iss_is_imm      <= is_imm;
            iss_is_word     <= is_word;
            iss_is_unsigned <= is_unsigned;
        end
        wb_rd   <= iss_rd;
        wb_data <= alu_result;
    end

    // ##############################
    // alu
    // ##############################
    always_comb begin
        logic [rv_pkg::XLEN-1:0] op_b;
        logic [5:0]              shamt;
        logic [rv_pkg::XLEN-1:0] srl_src;
        logic [rv_pkg::XLEN-1:0] sra_src;
        logic                    lt;
        logic [rv_pkg::XLEN-1:0] res;
        op_b    = iss_is_imm ? iss_imm : iss_src2;
        shamt   = iss_is_word ? {1'b0, op_b[4:0]} : op_b[5:0];
        srl_src = iss_is_word ? {{(rv_pkg::XLEN-32){1'b0}}, iss_src1[31:0]} : iss_src1;
        sra_src = iss_is_word ? {{(rv_pkg::XLEN-32){iss_src1[31]}}, iss_src1[31:0]}
                              : iss_src1;
        lt      = iss_is_unsigned ? (iss_src1 < op_b) : ($signed(iss_src1) < $signed(op_b));
        case (iss_op)
            rv_pkg::ALU_ADD:   res = iss_src1 + op_b;
            rv_pkg::ALU_SUB:   res = iss_src1 - op_b;
            rv_pkg::ALU_SLL:   res = iss_src1 << shamt;
            rv_pkg::ALU_SLT:   res = {{(rv_pkg::XLEN-1){1'b0}}, lt};
            rv_pkg::ALU_XOR:   res = iss_src1 ^ op_b;
            rv_pkg::ALU_SRL:   res = srl_src >> shamt;
            rv_pkg::ALU_SRA:   res = $signed(sra_src) >>> shamt;
            rv_pkg::ALU_OR:    res = iss_src1 | op_b;
            rv_pkg::ALU_AND:   res = iss_src1 & op_b;
            rv_pkg::ALU_LUI:   res = iss_imm;
            rv_pkg::ALU_AUIPC: res = iss_pc + iss_imm;
            default:           res = '0;
        endcase
        // word ops keep the low half, sign-extended
        alu_result = iss_is_word ? {{(rv_pkg::XLEN-32){res[31]}}, res[31:0]} : res;
    end

endmodule

// ==== rtl/exec_core.sv ====
`timescale 1ns/100ps

module exec_core #(
    parameter int                      FIFO_DEPTH = 8,
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC   = '0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [rv_pkg::ILEN-1:0]       wb_dat_w,
    output logic                          wb_ack,
    output logic [rv_pkg::ILEN-1:0]       wb_dat_r,
    output logic                          wb_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [rv_pkg::XLEN-1:0]       wb_data
);

    logic                          fifo_empty;
    logic                          fifo_pop;
    logic [rv_pkg::ILEN-1:0]       fifo_head;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    logic [rv_pkg::XLEN-1:0]       src1;
    logic [rv_pkg::XLEN-1:0]       src2;
    logic [rv_pkg::XLEN-1:0]       imm;
    rv_pkg::alu_op_e               alu_op;
    logic                          is_imm;
    logic                          is_word;
    logic                          is_unsigned;
    logic                          need_to_wb;

    inst_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_dat_w(wb_dat_w),
        .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
        .pop(fifo_pop), .empty(fifo_empty), .head(fifo_head)
    );

    decoder i_decoder (
        .empty(fifo_empty), .inst(fifo_head),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1(rs1), .rs2(rs2), .rd(rd), .src1(src1), .src2(src2), .imm(imm),
        .alu_op(alu_op), .is_imm(is_imm), .is_word(is_word),
        .is_unsigned(is_unsigned), .need_to_wb(need_to_wb)
    );

    // writeback port doubles as the register file write port
    reg_file i_regs (
        .clk(clk), .rst_n(rst_n),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(wb_valid), .wa(wb_rd), .wd(wb_data)
    );

    execute_stage #(.RESET_PC(RESET_PC)) i_exec (
        .clk(clk), .rst_n(rst_n), .empty(fifo_empty), .pop(fifo_pop),
        .rs1(rs1), .rs2(rs2), .rd(rd), .src1(src1), .src2(src2), .imm(imm),
        .alu_op(alu_op), .is_imm(is_imm), .is_word(is_word),
        .is_unsigned(is_unsigned), .need_to_wb(need_to_wb),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

// ==== tests/exec_core_props.sv ====
`timescale 1ns/100ps

module exec_core_props (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic                          wb_ack,
    input logic                          wb_valid,
    input logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    input logic [rv_pkg::REG_ADDR_W-1:0] rd
);

    // ##############################
    // wishbone handshake
    // ##############################
    property ack_inside_request;
        @(posedge clk) disable iff (!rst_n)
            wb_ack |-> (wb_cyc && wb_stb);
    endproperty

    property ack_single_cycle;
        @(posedge clk) disable iff (!rst_n)
            wb_ack |=> !wb_ack;
    endproperty

    // decode to writeback is two edges, so x0 in writeback must come from an x0 decode
    property wb_rd_zero_only_for_x0;
        @(posedge clk) disable iff (!rst_n)
            (wb_valid && wb_rd == '0) |-> ($past(rd, 2) == '0);
    endproperty

    a_ack_inside_request: assert property (ack_inside_request)
        else $error("wb_ack raised outside cyc and stb");
    a_ack_single_cycle: assert property (ack_single_cycle)
        else $error("wb_ack high for two cycles in a row");
    a_wb_rd_zero_only_for_x0: assert property (wb_rd_zero_only_for_x0)
        else $error("writeback to x0 for an instruction decoded with a nonzero rd");

endmodule

bind exec_core exec_core_props i_props (
    .clk(clk), .rst_n(rst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .rd(rd)
);

// ==== tests/tb_exec_core.sv ====
`timescale 1ns/100ps

module tb_exec_core;

    localparam logic [63:0] START_PC    = 64'h1000;
    localparam int          ACK_TIMEOUT = 50;    // cycles
    localparam int          WB_TIMEOUT  = 100;
    localparam int          SETTLE      = 20;
    localparam int          BURST_START = 35;    // entries from here on are written back to back

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_dat_w;
    logic        wb_ack;
    logic [31:0] wb_dat_r;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [63:0] wb_data;

    logic [31:0] tbl_inst [64];
    logic        tbl_wb   [64];
    logic [4:0]  tbl_rd   [64];
    logic [63:0] tbl_val  [64];
    int          n_entries;
    logic [31:0] rd_word;

    exec_core #(.FIFO_DEPTH(8), .RESET_PC(START_PC)) i_dut (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_dat_w(wb_dat_w),
        .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    always #4 clk = ~clk;

    // ##############################
    // encoders and table
    // ##############################
    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] opc, input logic [6:0] f7,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    task automatic add_entry(input logic [31:0] inst, input logic wb,
                             input logic [4:0] rd, input logic [63:0] val);
        tbl_inst[n_entries] = inst;
        tbl_wb[n_entries]   = wb;
        tbl_rd[n_entries]   = rd;
        tbl_val[n_entries]  = val;
        n_entries++;
    endtask

    task automatic build_table;
        logic [11:0] s_imm;
        logic [12:0] b_imm;
        n_entries = 0;
        s_imm = 12'd8;
        b_imm = 13'd16;
        add_entry(enc_u(7'h37, 1, 20'h12345), 1, 1, 64'h0000_0000_1234_5000);      // lui
        add_entry(enc_u(7'h37, 2, 20'h80000), 1, 2, 64'hffff_ffff_8000_0000);
        add_entry(enc_i(7'h13, 0, 3, 0, -12'sd5), 1, 3, 64'hffff_ffff_ffff_fffb);
        add_entry(enc_u(7'h17, 4, 20'h00001), 1, 4, 64'h0000_0000_0000_200c);      // pc 0x100c
        add_entry(enc_i(7'h13, 0, 5, 0, 12'd100), 1, 5, 64'd100);
        add_entry(enc_r(7'h33, 7'h00, 0, 6, 5, 3), 1, 6, 64'd95);                  // add
        add_entry(enc_r(7'h33, 7'h20, 0, 7, 3, 5), 1, 7, 64'hffff_ffff_ffff_ff97); // sub
        add_entry(enc_i(7'h13, 1, 8, 5, 12'd33), 1, 8, 64'h0000_00c8_0000_0000);   // slli
        add_entry(enc_i(7'h13, 5, 9, 3, 12'd60), 1, 9, 64'hf);                     // srli
        add_entry(enc_i(7'h13, 5, 10, 2, 12'h404), 1, 10, 64'hffff_ffff_f800_0000);
        add_entry(enc_r(7'h33, 7'h00, 2, 11, 3, 5), 1, 11, 64'd1);                 // slt
        add_entry(enc_r(7'h33, 7'h00, 3, 12, 3, 5), 1, 12, 64'd0);                 // sltu
        add_entry(enc_i(7'h13, 3, 13, 5, 12'hfff), 1, 13, 64'd1);                  // sltiu
        add_entry(enc_r(7'h33, 7'h00, 4, 14, 1, 5), 1, 14, 64'h0000_0000_1234_5064);
        add_entry(enc_r(7'h33, 7'h00, 6, 15, 2, 5), 1, 15, 64'hffff_ffff_8000_0064);
        add_entry(enc_i(7'h13, 7, 16, 3, 12'h0f0), 1, 16, 64'hf0);                 // andi
        add_entry(enc_r(7'h33, 7'h00, 5, 17, 2, 5), 1, 17, 64'h0000_0000_0fff_ffff);
        add_entry(enc_r(7'h33, 7'h20, 5, 18, 2, 5), 1, 18, 64'hffff_ffff_ffff_ffff);
        add_entry(enc_r(7'h33, 7'h00, 1, 19, 1, 5), 1, 19, 64'h2345_0000_0000_0000);
        // word variants
        add_entry(enc_r(7'h3b, 7'h00, 0, 20, 2, 3), 1, 20, 64'h0000_0000_7fff_fffb);
        add_entry(enc_r(7'h3b, 7'h20, 0, 21, 1, 2), 1, 21, 64'hffff_ffff_9234_5000);
        add_entry(enc_i(7'h1b, 1, 22, 1, 12'd3), 1, 22, 64'hffff_ffff_91a2_8000);
        add_entry(enc_r(7'h3b, 7'h20, 5, 23, 2, 5), 1, 23, 64'hffff_ffff_f800_0000);
        // dependent chain
        add_entry(enc_i(7'h13, 0, 24, 0, 12'd7), 1, 24, 64'd7);
        add_entry(enc_i(7'h13, 0, 24, 24, 12'd3), 1, 24, 64'd10);
        add_entry(enc_i(7'h13, 1, 25, 24, 12'd2), 1, 25, 64'd40);
        add_entry(enc_r(7'h33, 7'h00, 0, 26, 25, 24), 1, 26, 64'd50);
        add_entry(enc_r(7'h33, 7'h20, 0, 26, 26, 25), 1, 26, 64'd10);
        add_entry(enc_i(7'h13, 0, 0, 0, 12'd55), 1, 0, 64'd55);                    // to x0
        add_entry(enc_r(7'h33, 7'h00, 0, 27, 0, 26), 1, 27, 64'd10);
        // consumed without writeback
        add_entry(enc_i(7'h03, 2, 28, 1, 12'd0), 0, 0, 64'd0);                     // lw
        add_entry({s_imm[11:5], 5'd5, 5'd1, 3'd3, s_imm[4:0], 7'h23}, 0, 0, 64'd0);
        add_entry({b_imm[12], b_imm[10:5], 5'd2, 5'd1, 3'd0, b_imm[4:1], b_imm[11], 7'h63},
                  0, 0, 64'd0);
        add_entry(32'h0ff0_000f, 0, 0, 64'd0);                                     // fence
        add_entry(enc_u(7'h17, 28, 20'h00000), 1, 28, 64'h0000_0000_0000_1088);
        // burst, deeper than the FIFO
        for (int k = 1; k <= 10; k++)
            add_entry(enc_i(7'h13, 0, 29, 29, 12'd1), 1, 29, 64'(k));
        add_entry(enc_u(7'h17, 31, 20'hfffff), 1, 31, 64'h0000_0000_0000_00b4);
    endtask

    // ##############################
    // checks and bus driver
    // ##############################
    task automatic fail_run(input string why);
        $display("%s at %0t", why, $time);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic wait_ack(input string why);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ACK_TIMEOUT)
                fail_run(why);
        end while (!wb_ack);
    endtask

    task automatic wb_write(input logic [31:0] word);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_dat_w = word;
        wait_ack("no ack on a Wishbone write");
        @(posedge clk);    // ack is taken on the edge that closes its cycle
        #1;
        wb_cyc = 1'b0;   // stb dropped once ack is seen
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wait_ack("no ack on a Wishbone read");
        data = wb_dat_r;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic drive_all;
        int gap;
        for (int i = 0; i < n_entries; i++) begin
            gap = (i >= BURST_START) ? 0 : int'($urandom % 4);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            wb_write(tbl_inst[i]);
        end
    endtask

    task automatic check_writebacks;
        int cycles;
        for (int i = 0; i < n_entries; i++) begin
            if (tbl_wb[i]) begin
                cycles = 0;
                do begin
                    @(negedge clk);
                    cycles++;
                    if (cycles > WB_TIMEOUT)
                        fail_run("expected writeback never arrived");
                end while (!wb_valid);
                check("wb_rd", 64'(wb_rd), 64'(tbl_rd[i]));
                check("wb_data", wb_data, tbl_val[i]);
            end
        end
        for (int c = 0; c < SETTLE; c++) begin
            @(negedge clk);
            if (wb_valid)
                fail_run("extra writeback after the last instruction");
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_dat_w = '0;
        void'($urandom(32'hef77bd05));
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // write-only port, a read is acked with zero data
        wb_read(rd_word);
        check("wb_dat_r", 64'(rd_word), 64'd0);
        fork
            drive_all();
            check_writebacks();
        join
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== files.f ====
rtl/rv_pkg.sv
rtl/inst_fifo.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/exec_core.sv
tests/exec_core_props.sv
tests/tb_exec_core.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_exec_core
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
